// File: Makefile
# Verilator build and run for the reduced 8080 core

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= i8080_tb
RTL_TOP    ?= i8080_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= -Wall
PASS_MSG   ?= All checks passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation PASS" || (echo "Simulation FAIL"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
design/i8080_isa_pkg.sv
design/i8080_core_pkg.sv
design/i8080_decoder.sv
design/i8080_alu.sv
design/i8080_regfile.sv
design/i8080_sequencer.sv
design/i8080_top.sv
tb/tb_clock_gen.sv
tb/i8080_tb.sv

// File: design/i8080_alu.sv
// 8-bit ALU with 8080 flag rules; AC for subtract is the 8080 inverted-borrow form
`timescale 1ns/10ps

module i8080_alu
	import i8080_isa_pkg::*;
(
	input  alu_op_e    i_op,
	input  logic [7:0] i_a,
	input  logic [7:0] i_b,
	input  flags_t     i_flags,
	output logic [7:0] o_result,
	output flags_t     o_flags
);

	logic [8:0] w_sum;
	logic [4:0] w_half;
	logic       w_cin;
	logic       w_cy;
	logic       w_ac;

	always_comb begin
		w_sum  = '0;
		w_half = '0;
		w_cin  = 1'b0;
		w_cy   = i_flags.cy;
		w_ac   = i_flags.ac;
		case (i_op)
			ALU_ADD, ALU_ADC: begin
				w_cin  = (i_op == ALU_ADC) & i_flags.cy;
				w_sum  = {1'b0, i_a} + {1'b0, i_b} + 9'(w_cin);
				w_half = {1'b0, i_a[3:0]} + {1'b0, i_b[3:0]} + 5'(w_cin);
				w_cy   = w_sum[8];
				w_ac   = w_half[4];
			end
			ALU_SUB, ALU_SBB, ALU_CMP: begin
				// Add the complement, carry out is inverted borrow
				w_cin  = ~((i_op == ALU_SBB) & i_flags.cy);
				w_sum  = {1'b0, i_a} + {1'b0, ~i_b} + 9'(w_cin);
				w_half = {1'b0, i_a[3:0]} + {1'b0, ~i_b[3:0]} + 5'(w_cin);
				w_cy   = ~w_sum[8];
				w_ac   = w_half[4];
			end
			ALU_AND: begin
				w_sum = {1'b0, i_a & i_b};
				w_cy  = 1'b0;
				w_ac  = i_a[3] | i_b[3];
			end
			ALU_XOR: begin
				w_sum = {1'b0, i_a ^ i_b};
				w_cy  = 1'b0;
				w_ac  = 1'b0;
			end
			ALU_OR: begin
				w_sum = {1'b0, i_a | i_b};
				w_cy  = 1'b0;
				w_ac  = 1'b0;
			end
			ALU_INR: begin
				// Carry untouched
				w_sum = {1'b0, i_a + 8'd1};
				w_ac  = (w_sum[3:0] == 4'h0);
			end
			ALU_DCR: begin
				w_sum = {1'b0, i_a - 8'd1};
				w_ac  = (w_sum[3:0] != 4'hF);
			end
			default: begin
				w_sum = {1'b0, i_b};
			end
		endcase
	end

	assign o_result = w_sum[7:0];

	always_comb begin
		if (i_op == ALU_PASS) begin
			o_flags = i_flags;
		end else begin
			o_flags.s  = w_sum[7];
			o_flags.z  = (w_sum[7:0] == 8'h00);
			o_flags.ac = w_ac;
			o_flags.p  = ~^w_sum[7:0];
			o_flags.cy = w_cy;
		end
	end

endmodule

// File: design/i8080_core_pkg.sv
// Sequencer and bus types; the bus address field is fixed at 16 bits
package i8080_core_pkg;
	import i8080_isa_pkg::*;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_OPER1,
		ST_OPER2,
		ST_WRITE,   // data cycle, a read for LDA
		ST_EXEC,
		ST_HALT
	} seq_state_e;

	// One decoded instruction, held for its whole length
	typedef struct packed {
		op_class_e  cls;
		alu_op_e    alu_op;
		reg_code_e  src;
		reg_code_e  dst;
		cond_e      cond;
		logic [1:0] n_oper;
		logic       wb;
	} decoded_t;

	// Bus request toward the pins
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dat_w;
		logic        rd;
		logic        wr;
		logic        io;
	} bus_req_t;

endpackage

// File: design/i8080_decoder.sv
// Opcode decoder; all stack, pair, rotate, IN and M forms come out as ILLEGAL
`timescale 1ns/10ps

module i8080_decoder
	import i8080_isa_pkg::*;
	import i8080_core_pkg::*;
(
	input  logic [7:0] i_opcode,
	output decoded_t   o_dec
);

	logic [1:0] w_grp;
	logic [2:0] w_mid;
	logic [2:0] w_low;

	assign w_grp = i_opcode[7:6];
	assign w_mid = i_opcode[5:3];
	assign w_low = i_opcode[2:0];

	always_comb begin
		// Field defaults, overridden per group
		o_dec.cls    = CL_ILLEGAL;
		o_dec.alu_op = ALU_PASS;
		o_dec.src    = reg_code_e'(w_low);
		o_dec.dst    = reg_code_e'(w_mid);
		o_dec.cond   = cond_e'(w_mid);
		o_dec.n_oper = 2'd0;
		o_dec.wb     = 1'b0;

		case (w_grp)
			2'b00: begin
				if (i_opcode == 8'h00) begin
					o_dec.cls = CL_NOP;
				end else if (i_opcode == 8'h32) begin
					o_dec.cls    = CL_STA;
					o_dec.n_oper = 2'd2;
				end else if (i_opcode == 8'h3A) begin
					o_dec.cls    = CL_LDA;
					o_dec.dst    = R_A;
					o_dec.n_oper = 2'd2;
					o_dec.wb     = 1'b1;
				end else if (w_mid != 3'd6) begin
					if (w_low == 3'b110) begin
						o_dec.cls    = CL_MVI;
						o_dec.n_oper = 2'd1;
						o_dec.wb     = 1'b1;
					end else if (w_low == 3'b100 || w_low == 3'b101) begin
						o_dec.cls    = CL_INR_DCR;
						o_dec.alu_op = w_low[0] ? ALU_DCR : ALU_INR;
						o_dec.wb     = 1'b1;
					end
				end
			end
			2'b01: begin
				// 76h sits where MOV M,M would be
				if (i_opcode == 8'h76) begin
					o_dec.cls = CL_HLT;
				end else if (w_low != 3'd6 && w_mid != 3'd6) begin
					o_dec.cls = CL_MOV;
					o_dec.wb  = 1'b1;
				end
			end
			2'b10: begin
				if (w_low != 3'd6) begin
					o_dec.cls    = CL_ALU_R;
					o_dec.alu_op = alu_op_e'({1'b0, w_mid});
					o_dec.dst    = R_A;
					o_dec.wb     = (w_mid != 3'd7);
				end
			end
			default: begin
				if (w_low == 3'b110) begin
					o_dec.cls    = CL_ALU_I;
					o_dec.alu_op = alu_op_e'({1'b0, w_mid});
					o_dec.dst    = R_A;
					o_dec.n_oper = 2'd1;
					o_dec.wb     = (w_mid != 3'd7);
				end else if (i_opcode == 8'hC3) begin
					o_dec.cls    = CL_JMP;
					o_dec.n_oper = 2'd2;
				end else if (w_low == 3'b010) begin
					o_dec.cls    = CL_JCC;
					o_dec.n_oper = 2'd2;
				end else if (i_opcode == 8'hD3) begin
					o_dec.cls    = CL_OUT;
					o_dec.n_oper = 2'd1;
				end
			end
		endcase
	end

	// MOV with M must never reach the register file
	always_comb begin
		assert final (o_dec.cls != CL_MOV || (o_dec.src != 3'd6 && o_dec.dst != 3'd6))
			else $error("MOV decoded with M operand");
	end

endmodule

// File: design/i8080_isa_pkg.sv
// 8080 instruction-set types; register code 6 (M) has no storage in this reduced core
package i8080_isa_pkg;

	// ********************
	// Register field codes
	// ********************
	typedef enum logic [2:0] {
		R_B = 3'd0,
		R_C = 3'd1,
		R_D = 3'd2,
		R_E = 3'd3,
		R_H = 3'd4,
		R_L = 3'd5,
		R_A = 3'd7
	} reg_code_e;

	// Codes 0..7 follow the opcode field of the ALU group
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_ADC  = 4'd1,
		ALU_SUB  = 4'd2,
		ALU_SBB  = 4'd3,
		ALU_AND  = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_CMP  = 4'd7,
		ALU_INR  = 4'd8,
		ALU_DCR  = 4'd9,
		ALU_PASS = 4'd10
	} alu_op_e;

	// Jump conditions, same order as bits 5..3 of Jcc
	typedef enum logic [2:0] {
		C_NZ = 3'd0,
		C_Z  = 3'd1,
		C_NC = 3'd2,
		C_C  = 3'd3,
		C_PO = 3'd4,
		C_PE = 3'd5,
		C_P  = 3'd6,
		C_M  = 3'd7
	} cond_e;

	typedef struct packed {
		logic s;
		logic z;
		logic ac;
		logic p;
		logic cy;
	} flags_t;

	// ********************
	// Instruction classes
	// ********************
	typedef enum logic [3:0] {
		CL_MOV,
		CL_MVI,
		CL_ALU_R,
		CL_ALU_I,
		CL_INR_DCR,
		CL_LDA,
		CL_STA,
		CL_JMP,
		CL_JCC,
		CL_OUT,
		CL_NOP,
		CL_HLT,
		CL_ILLEGAL
	} op_class_e;

endpackage

// File: design/i8080_regfile.sv
// Registers B..L, A and flags; code 6 reads as zero and must never be written
`timescale 1ns/10ps

module i8080_regfile
	import i8080_isa_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  reg_code_e  i_src_sel,
	input  reg_code_e  i_dst_sel,
	input  logic       i_wr_en,
	input  logic [7:0] i_wr_data,
	input  logic       i_flags_en,
	input  flags_t     i_flags,
	output logic [7:0] o_src,
	output logic [7:0] o_dst,
	output logic [7:0] o_acc,
	output flags_t     o_flags
);

	logic [7:0] r_b, r_c, r_d, r_e, r_h, r_l, r_a;
	flags_t     r_flags;

	function automatic logic [7:0] read_reg(input reg_code_e sel);
		case (sel)
			R_B:     return r_b;
			R_C:     return r_c;
			R_D:     return r_d;
			R_E:     return r_e;
			R_H:     return r_h;
			R_L:     return r_l;
			R_A:     return r_a;
			default: return 8'h00;
		endcase
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_b     <= '0;
			r_c     <= '0;
			r_d     <= '0;
			r_e     <= '0;
			r_h     <= '0;
			r_l     <= '0;
			r_a     <= '0;
			r_flags <= '0;
		end else begin
			if (i_wr_en) begin
				case (i_dst_sel)
					R_B:     r_b <= i_wr_data;
					R_C:     r_c <= i_wr_data;
					R_D:     r_d <= i_wr_data;
					R_E:     r_e <= i_wr_data;
					R_H:     r_h <= i_wr_data;
					R_L:     r_l <= i_wr_data;
					R_A:     r_a <= i_wr_data;
					default: ;
				endcase
			end
			if (i_flags_en) begin
				r_flags <= i_flags;
			end
		end
	end

	assign o_src   = read_reg(i_src_sel);
	assign o_dst   = read_reg(i_dst_sel);
	assign o_acc   = r_a;
	assign o_flags = r_flags;

	// A write to M means the decoder let an indirect form through
	a_no_wr_m: assert property (@(posedge i_clk) disable iff (i_rst)
		i_wr_en |-> (i_dst_sel != 3'd6));

endmodule

// File: design/i8080_sequencer.sv
// Bus sequencer; strobes last one cycle, i_ready must pulse once per cycle, HALT exits by reset only
`timescale 1ns/10ps

module i8080_sequencer
	import i8080_isa_pkg::*;
	import i8080_core_pkg::*;
#(
	parameter int P_ADDR_W   = 16,
	parameter int P_RESET_PC = 0
) (
	input  logic       i_clk,
	input  logic       i_rst,
	input  logic       i_ready,
	input  logic [7:0] i_dat_r,
	input  decoded_t   i_dec,
	input  logic [7:0] i_alu_result,
	input  flags_t     i_alu_flags,
	input  logic [7:0] i_src,
	input  logic [7:0] i_acc,
	input  flags_t     i_flags,
	output logic [7:0] o_opcode,
	output bus_req_t   o_bus,
	output reg_code_e  o_src_sel,
	output reg_code_e  o_dst_sel,
	output alu_op_e    o_alu_op,
	output logic [7:0] o_alu_b,
	output logic       o_wr_en,
	output logic [7:0] o_wr_data,
	output logic       o_flags_en
);

	seq_state_e          r_state;
	logic                r_busy;
	bus_req_t            r_bus;
	logic [P_ADDR_W-1:0] r_pc;
	logic [7:0]          r_ir;
	logic [7:0]          r_op1;
	logic [7:0]          r_op2;
	decoded_t            r_dec;
	logic                w_fetch_rdy;
	logic                w_exec;
	logic                w_taken;
	logic [P_ADDR_W-1:0] w_target;
	logic [P_ADDR_W-1:0] w_next_pc;

	function automatic logic cond_true(input cond_e c, input flags_t f);
		case (c)
			C_NZ:    return ~f.z;
			C_Z:     return f.z;
			C_NC:    return ~f.cy;
			C_C:     return f.cy;
			C_PO:    return ~f.p;
			C_PE:    return f.p;
			C_P:     return ~f.s;
			default: return f.s;
		endcase
	endfunction

	// Opcode goes to the decoder straight from the bus on the fetch ready
	assign w_fetch_rdy = (r_state == ST_FETCH) && r_busy && i_ready;
	assign o_opcode    = w_fetch_rdy ? i_dat_r : r_ir;

	assign w_exec    = (r_state == ST_EXEC);
	assign w_target  = P_ADDR_W'({r_op2, r_op1});
	assign w_taken   = (r_dec.cls == CL_JMP) ||
		((r_dec.cls == CL_JCC) && cond_true(r_dec.cond, i_flags));
	assign w_next_pc = w_taken ? w_target : r_pc;

	// ********************
	// Bus cycle FSM
	// ********************
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state  <= ST_FETCH;
			r_busy   <= 1'b0;
			r_pc     <= P_ADDR_W'(P_RESET_PC);
			r_bus.rd <= 1'b0;
			r_bus.wr <= 1'b0;
			r_bus.io <= 1'b0;
		end else begin
			r_bus.rd <= 1'b0;
			r_bus.wr <= 1'b0;
			case (r_state)
				ST_FETCH, ST_OPER1, ST_OPER2: begin
					if (!r_busy) begin
						r_bus.addr <= 16'(r_pc);
						r_bus.rd   <= 1'b1;
						r_pc       <= r_pc + 1'b1;
						r_busy     <= 1'b1;
					end else if (i_ready) begin
						r_busy <= 1'b0;
						if (r_state == ST_FETCH) begin
							r_ir  <= i_dat_r;
							r_dec <= i_dec;
							if (i_dec.cls == CL_HLT || i_dec.cls == CL_ILLEGAL) begin
								r_state <= ST_HALT;
							end else if (i_dec.cls == CL_JCC &&
									!cond_true(i_dec.cond, i_flags)) begin
								// Not taken, step over the address bytes
								r_pc    <= r_pc + P_ADDR_W'(2);
								r_state <= ST_EXEC;
							end else if (i_dec.n_oper == 2'd0) begin
								r_state <= ST_EXEC;
							end else begin
								r_state <= ST_OPER1;
							end
						end else if (r_state == ST_OPER1) begin
							r_op1 <= i_dat_r;
							if (r_dec.n_oper == 2'd2) begin
								r_state <= ST_OPER2;
							end else if (r_dec.cls == CL_OUT) begin
								r_state <= ST_WRITE;
							end else begin
								r_state <= ST_EXEC;
							end
						end else begin
							r_op2 <= i_dat_r;
							if (r_dec.cls == CL_STA || r_dec.cls == CL_LDA) begin
								r_state <= ST_WRITE;
							end else begin
								r_state <= ST_EXEC;
							end
						end
					end
				end
				ST_WRITE: begin
					if (!r_busy) begin
						// Port number shows on both address halves
						r_bus.addr  <= (r_dec.cls == CL_OUT) ? {r_op1, r_op1} : {r_op2, r_op1};
						r_bus.dat_w <= i_acc;
						r_bus.rd    <= (r_dec.cls == CL_LDA);
						r_bus.wr    <= (r_dec.cls != CL_LDA);
						r_bus.io    <= (r_dec.cls == CL_OUT);
						r_busy      <= 1'b1;
					end else if (i_ready) begin
						r_busy   <= 1'b0;
						r_bus.io <= 1'b0;
						if (r_dec.cls == CL_LDA) begin
							r_op1 <= i_dat_r;
						end
						r_state <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					// Write-back happens here, next fetch goes out at once
					r_bus.addr <= 16'(w_next_pc);
					r_bus.rd   <= 1'b1;
					r_pc       <= w_next_pc + 1'b1;
					r_busy     <= 1'b1;
					r_state    <= ST_FETCH;
				end
				default: ;
			endcase
		end
	end

	assign o_bus = r_bus;

	// Register file and ALU control
	assign o_src_sel  = r_dec.src;
	assign o_dst_sel  = r_dec.dst;
	assign o_alu_op   = r_dec.alu_op;
	assign o_alu_b    = (r_dec.cls == CL_ALU_I) ? r_op1 : i_src;
	assign o_wr_en    = w_exec && r_dec.wb;
	assign o_flags_en = w_exec && (r_dec.cls == CL_ALU_R || r_dec.cls == CL_ALU_I ||
		r_dec.cls == CL_INR_DCR);

	always_comb begin
		case (r_dec.cls)
			CL_MOV:         o_wr_data = i_src;
			CL_MVI, CL_LDA: o_wr_data = r_op1;
			default:        o_wr_data = i_alu_result;
		endcase
	end

	// ********************
	// Bus checks
	// ********************
	a_rd_wr_excl: assert property (@(posedge i_clk) disable iff (i_rst)
		!(r_bus.rd && r_bus.wr));
	a_rd_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		r_bus.rd |=> !r_bus.rd);
	a_wr_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
		r_bus.wr |=> !r_bus.wr);
	a_addr_hold: assert property (@(posedge i_clk) disable iff (i_rst)
		(r_busy && !i_ready) |=> $stable(r_bus.addr));

endmodule

// File: design/i8080_top.sv
// Reduced 8080 core top; no interrupts, one-cycle strobes answered by one-cycle i_ready
`timescale 1ns/10ps

module i8080_top
	import i8080_isa_pkg::*;
	import i8080_core_pkg::*;
#(
	parameter int P_ADDR_W   = 16,
	parameter int P_RESET_PC = 0
) (
	input  logic                i_clk,
	input  logic                i_rst,
	input  logic                i_ready,
	input  logic [7:0]          i_dat_r,
	output logic [P_ADDR_W-1:0] o_addr,
	output logic [7:0]          o_dat_w,
	output logic                o_read,
	output logic                o_write,
	output logic                o_io
);

	logic [7:0] w_opcode;
	decoded_t   w_dec;
	bus_req_t   w_bus;
	reg_code_e  w_src_sel;
	reg_code_e  w_dst_sel;
	alu_op_e    w_alu_op;
	logic [7:0] w_alu_b;
	logic [7:0] w_alu_result;
	flags_t     w_alu_flags;
	logic       w_wr_en;
	logic [7:0] w_wr_data;
	logic       w_flags_en;
	logic [7:0] w_src;
	logic [7:0] w_dst;
	logic [7:0] w_acc;
	flags_t     w_flags;

	i8080_decoder u_decoder (
		.i_opcode (w_opcode),
		.o_dec    (w_dec)
	);

	// Destination register is the A operand, also for INR and DCR
	i8080_alu u_alu (
		.i_op     (w_alu_op),
		.i_a      (w_dst),
		.i_b      (w_alu_b),
		.i_flags  (w_flags),
		.o_result (w_alu_result),
		.o_flags  (w_alu_flags)
	);

	i8080_regfile u_regfile (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_src_sel  (w_src_sel),
		.i_dst_sel  (w_dst_sel),
		.i_wr_en    (w_wr_en),
		.i_wr_data  (w_wr_data),
		.i_flags_en (w_flags_en),
		.i_flags    (w_alu_flags),
		.o_src      (w_src),
		.o_dst      (w_dst),
		.o_acc      (w_acc),
		.o_flags    (w_flags)
	);

	i8080_sequencer #(
		.P_ADDR_W   (P_ADDR_W),
		.P_RESET_PC (P_RESET_PC)
	) u_sequencer (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_ready      (i_ready),
		.i_dat_r      (i_dat_r),
		.i_dec        (w_dec),
		.i_alu_result (w_alu_result),
		.i_alu_flags  (w_alu_flags),
		.i_src        (w_src),
		.i_acc        (w_acc),
		.i_flags      (w_flags),
		.o_opcode     (w_opcode),
		.o_bus        (w_bus),
		.o_src_sel    (w_src_sel),
		.o_dst_sel    (w_dst_sel),
		.o_alu_op     (w_alu_op),
		.o_alu_b      (w_alu_b),
		.o_wr_en      (w_wr_en),
		.o_wr_data    (w_wr_data),
		.o_flags_en   (w_flags_en)
	);

	// Pins
	assign o_addr  = P_ADDR_W'(w_bus.addr);
	assign o_dat_w = w_bus.dat_w;
	assign o_read  = w_bus.rd;
	assign o_write = w_bus.wr;
	assign o_io    = w_bus.io;

endmodule

// File: tb/i8080_tb.sv
// Testbench for the reduced 8080 core; program sits below 8000h and data stores land at 8000h and up
`timescale 1ns/10ps

module i8080_tb;

	typedef struct packed {
		logic s;
		logic z;
		logic ac;
		logic p;
		logic cy;
	} ref_flags_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        io;
	} write_t;

	logic        clk;
	logic        rst;
	logic        bus_ready = 1'b0;
	logic [7:0]  bus_rdata = 8'h00;
	logic [15:0] bus_addr;
	logic [7:0]  bus_wdata;
	logic        bus_read;
	logic        bus_write;
	logic        bus_io;
	logic        hlt_fetched = 1'b0;

	logic [7:0]  mem [0:65535];
	logic [7:0]  ref_mem [0:65535];
	logic [7:0]  ref_reg [0:7];
	ref_flags_t  ref_f;
	write_t      exp_q [$];
	write_t      expected_wr;

	integer      seed;
	logic [15:0] gen_pc;
	logic [15:0] hlt_pc;
	int          ref_steps;
	int          cycle_limit = 0;
	int          cycle_count = 0;
	int          cycles_since_reset = 0;
	int          strobes_after_halt = 0;
	int          writes_seen = 0;
	bit          first_seen = 1'b0;

	// Memory model state
	logic [15:0] cyc_addr;
	logic        cyc_rd;
	bit          pending = 1'b0;
	bit          respond;
	logic [1:0]  wait_left;
	logic [31:0] mem_rnd;

	tb_clock_gen #(
		.P_PERIOD     (20),
		.P_RST_CYCLES (10)
	) u_clock_gen (
		.o_clk (clk),
		.o_rst (rst)
	);

	i8080_top #(
		.P_ADDR_W   (16),
		.P_RESET_PC (0)
	) DUT (
		.i_clk   (clk),
		.i_rst   (rst),
		.i_ready (bus_ready),
		.i_dat_r (bus_rdata),
		.o_addr  (bus_addr),
		.o_dat_w (bus_wdata),
		.o_read  (bus_read),
		.o_write (bus_write),
		.o_io    (bus_io)
	);

	task automatic stop_on_failure(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic compare_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			stop_on_failure($sformatf("[ERROR] %0t: %s is %0h, expected %0h", $time, what,
				got, exp));
		end
	endtask

	// ********************
	// Program image
	// ********************
	function automatic logic [7:0] rand_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Any register except the M slot
	function automatic logic [2:0] rand_reg();
		logic [31:0] r;
		r = $random(seed);
		return (r[2:0] == 3'd6) ? 3'd7 : r[2:0];
	endfunction

	function automatic logic [15:0] rand_data_addr();
		logic [31:0] r;
		r = $random(seed);
		return {1'b1, r[14:0]};
	endfunction

	task automatic put_byte(input logic [7:0] b);
		mem[gen_pc]     = b;
		ref_mem[gen_pc] = b;
		gen_pc          = gen_pc + 16'd1;
	endtask

	task automatic load_imm(input logic [2:0] r, input logic [7:0] v);
		put_byte({2'b00, r, 3'b110});
		put_byte(v);
	endtask

	task automatic move_reg(input logic [2:0] d, input logic [2:0] s);
		put_byte({2'b01, d, s});
	endtask

	task automatic alu_reg(input logic [2:0] op, input logic [2:0] s);
		put_byte({2'b10, op, s});
	endtask

	task automatic alu_imm(input logic [2:0] op, input logic [7:0] v);
		put_byte({2'b11, op, 3'b110});
		put_byte(v);
	endtask

	task automatic inr_dcr(input logic [2:0] r, input logic down);
		put_byte({2'b00, r, 2'b10, down});
	endtask

	task automatic store_acc(input logic [15:0] a);
		put_byte(8'h32);
		put_byte(a[7:0]);
		put_byte(a[15:8]);
	endtask

	task automatic load_acc(input logic [15:0] a);
		put_byte(8'h3A);
		put_byte(a[7:0]);
		put_byte(a[15:8]);
	endtask

	task automatic out_port(input logic [7:0] p);
		put_byte(8'hD3);
		put_byte(p);
	endtask

	// Per condition, OUT shows 10h|c when taken and 20h|c when not
	task automatic flag_probe();
		logic [15:0] target;
		for (int c = 0; c < 8; c++) begin
			target = gen_pc + 16'd7;
			load_imm(3'd7, 8'h10 | 8'(c));
			put_byte({2'b11, 3'(c), 3'b010});
			put_byte(target[7:0]);
			put_byte(target[15:8]);
			load_imm(3'd7, 8'h20 | 8'(c));
			out_port(8'h40 | 8'(c));
		end
	endtask

	task automatic build_program();
		logic [15:0] target;
		logic [15:0] addr;
		logic [7:0]  a;
		logic [7:0]  v;
		logic [2:0]  s;
		gen_pc = 16'h0000;
		// Jump over a stray HLT
		target = gen_pc + 16'd4;
		put_byte(8'hC3);
		put_byte(target[7:0]);
		put_byte(target[15:8]);
		put_byte(8'h76);
		for (int r = 0; r < 8; r++) begin
			if (r != 6) begin
				load_imm(3'(r), rand_byte());
			end
		end
		for (int r = 0; r < 6; r++) begin
			move_reg(3'd7, 3'(r));
			out_port(8'h10 + 8'(r));
		end
		// Value of B walks down the chain into A
		for (int r = 1; r < 6; r++) begin
			move_reg(3'(r), 3'(r - 1));
		end
		move_reg(3'd7, 3'd5);
		out_port(8'h1F);
		for (int op = 0; op < 8; op++) begin
			repeat (2) begin
				a = rand_byte();
				v = rand_byte();
				s = rand_reg();
				if (v[7:6] == 2'b00) begin
					v = a;
				end
				if (s != 3'd7) begin
					load_imm(s, v);
				end
				load_imm(3'd7, a);
				alu_reg(3'(op), s);
				store_acc(rand_data_addr());
				flag_probe();
				load_imm(3'd7, rand_byte());
				alu_imm(3'(op), rand_byte());
				store_acc(rand_data_addr());
				flag_probe();
			end
		end
		for (int k = 0; k < 4; k++) begin
			s = rand_reg();
			v = (k == 0) ? 8'hFF : (k == 1) ? 8'h00 : rand_byte();
			load_imm(s, v);
			inr_dcr(s, k[0]);
			move_reg(3'd7, s);
			store_acc(rand_data_addr());
			flag_probe();
		end
		// Store and load back through random addresses
		for (int k = 0; k < 8; k++) begin
			addr = rand_data_addr();
			load_imm(3'd7, rand_byte());
			store_acc(addr);
			load_imm(3'd7, rand_byte());
			load_acc(addr);
			out_port(8'h30 + 8'(k));
		end
		hlt_pc = gen_pc;
		put_byte(8'h76);
	endtask

	// ********************
	// Reference model
	// ********************
	function automatic void set_szp(input logic [7:0] r);
		ref_f.s = r[7];
		ref_f.z = (r == 8'h00);
		ref_f.p = ~^r;
	endfunction

	function automatic void alu_step(input logic [2:0] op, input logic [7:0] b);
		logic [7:0] a;
		logic [8:0] wide;
		logic [4:0] nib;
		logic       cin;
		a = ref_reg[7];
		case (op)
			3'd0, 3'd1: begin
				cin      = (op == 3'd1) & ref_f.cy;
				wide     = {1'b0, a} + {1'b0, b} + {8'd0, cin};
				nib      = {1'b0, a[3:0]} + {1'b0, b[3:0]} + {4'd0, cin};
				ref_f.cy = wide[8];
				ref_f.ac = nib[4];
			end
			3'd2, 3'd3, 3'd7: begin
				// Borrow in and out, AC is carry from bit 3 of a + ~b + 1
				cin      = (op == 3'd3) & ref_f.cy;
				wide     = {1'b0, a} - {1'b0, b} - {8'd0, cin};
				nib      = {1'b0, a[3:0]} + {1'b0, ~b[3:0]} + {4'd0, ~cin};
				ref_f.cy = wide[8];
				ref_f.ac = nib[4];
			end
			3'd4: begin
				wide     = {1'b0, a & b};
				ref_f.cy = 1'b0;
				ref_f.ac = a[3] | b[3];
			end
			3'd5: begin
				wide     = {1'b0, a ^ b};
				ref_f.cy = 1'b0;
				ref_f.ac = 1'b0;
			end
			default: begin
				wide     = {1'b0, a | b};
				ref_f.cy = 1'b0;
				ref_f.ac = 1'b0;
			end
		endcase
		set_szp(wide[7:0]);
		if (op != 3'd7) begin
			ref_reg[7] = wide[7:0];
		end
	endfunction

	// INR and DCR leave the carry alone
	function automatic logic [7:0] bump_value(input logic [7:0] v, input logic down);
		logic [7:0] r;
		r        = down ? v - 8'd1 : v + 8'd1;
		ref_f.ac = down ? (v[3:0] != 4'h0) : (v[3:0] == 4'hF);
		set_szp(r);
		return r;
	endfunction

	function automatic logic cond_holds(input logic [2:0] c);
		case (c)
			3'd0:    return !ref_f.z;
			3'd1:    return ref_f.z;
			3'd2:    return !ref_f.cy;
			3'd3:    return ref_f.cy;
			3'd4:    return !ref_f.p;
			3'd5:    return ref_f.p;
			3'd6:    return !ref_f.s;
			default: return ref_f.s;
		endcase
	endfunction

	function automatic void expect_write(input logic [15:0] a, input logic [7:0] d,
			input logic io);
		write_t w;
		w.addr = a;
		w.data = d;
		w.io   = io;
		exp_q.push_back(w);
	endfunction

	function automatic int run_reference();
		logic [15:0] pc;
		logic [7:0]  op;
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [2:0]  mid;
		logic [2:0]  low;
		int          steps;
		bit          halted;
		pc     = 16'h0000;
		steps  = 0;
		halted = 1'b0;
		ref_f  = '0;
		for (int r = 0; r < 8; r++) begin
			ref_reg[r] = 8'h00;
		end
		while (!halted && steps < 100000) begin
			op    = ref_mem[pc];
			b1    = ref_mem[pc + 16'd1];
			b2    = ref_mem[pc + 16'd2];
			mid   = op[5:3];
			low   = op[2:0];
			steps = steps + 1;
			pc    = pc + 16'd1;
			if (op == 8'h76) begin
				halted = 1'b1;
			end else if (op == 8'h00) begin
				pc = pc;
			end else if (op == 8'h32) begin
				expect_write({b2, b1}, ref_reg[7], 1'b0);
				ref_mem[{b2, b1}] = ref_reg[7];
				pc = pc + 16'd2;
			end else if (op == 8'h3A) begin
				ref_reg[7] = ref_mem[{b2, b1}];
				pc = pc + 16'd2;
			end else if (op == 8'hC3) begin
				pc = {b2, b1};
			end else if (op == 8'hD3) begin
				expect_write({b1, b1}, ref_reg[7], 1'b1);
				pc = pc + 16'd1;
			end else if (op[7:6] == 2'b01) begin
				ref_reg[mid] = ref_reg[low];
			end else if (op[7:6] == 2'b10) begin
				alu_step(mid, ref_reg[low]);
			end else if (op[7:6] == 2'b11 && low == 3'b110) begin
				alu_step(mid, b1);
				pc = pc + 16'd1;
			end else if (op[7:6] == 2'b11 && low == 3'b010) begin
				pc = cond_holds(mid) ? {b2, b1} : pc + 16'd2;
			end else if (op[7:6] == 2'b00 && low == 3'b110) begin
				ref_reg[mid] = b1;
				pc = pc + 16'd1;
			end else if (op[7:6] == 2'b00 && low[2:1] == 2'b10) begin
				ref_reg[mid] = bump_value(ref_reg[mid], low[0]);
			end else begin
				halted = 1'b1;
			end
		end
		return steps;
	endfunction

	// ********************
	// Memory model
	// ********************
	always @(posedge clk) begin
		bus_ready <= 1'b0;
		respond = 1'b0;
		if (pending) begin
			if (wait_left == 2'd1) begin
				respond = 1'b1;
				pending = 1'b0;
			end else begin
				wait_left = wait_left - 2'd1;
			end
		end else if (bus_read || bus_write) begin
			cyc_addr = bus_addr;
			cyc_rd   = bus_read;
			if (bus_write && !bus_io) begin
				mem[bus_addr] = bus_wdata;
			end
			// Ready follows 1 to 4 cycles after the strobe
			mem_rnd = $random(seed);
			if (mem_rnd[1:0] == 2'd0) begin
				respond = 1'b1;
			end else begin
				pending   = 1'b1;
				wait_left = mem_rnd[1:0];
			end
		end
		if (respond) begin
			bus_ready <= 1'b1;
			if (cyc_rd) begin
				bus_rdata <= mem[cyc_addr];
			end
			if (cyc_rd && cyc_addr == hlt_pc) begin
				hlt_fetched <= 1'b1;
			end
		end
	end

	// Reset quiet, first fetch and quiet after HLT
	always @(posedge clk) begin
		if (rst) begin
			cycles_since_reset = 0;
			if (bus_read || bus_write) begin
				stop_on_failure("A bus strobe appeared while reset was asserted");
			end
		end else begin
			cycles_since_reset = cycles_since_reset + 1;
			if ((bus_read || bus_write) && !first_seen) begin
				first_seen = 1'b1;
				// Strobe set on the first edge out of reset, seen on the next
				compare_value("cycles to first strobe", 32'(cycles_since_reset), 32'd2);
				compare_value("first strobe is a read", 32'(bus_read), 32'd1);
				compare_value("first fetch address", 32'(bus_addr), 32'h0000);
			end
			if (hlt_fetched && (bus_read || bus_write)) begin
				strobes_after_halt = strobes_after_halt + 1;
			end
		end
	end

	// Write comparator
	always @(posedge clk) begin
		if (!rst && bus_write) begin
			if (exp_q.size() == 0) begin
				stop_on_failure("The DUT wrote to the bus when no write was expected");
			end else begin
				expected_wr = exp_q.pop_front();
				compare_value("write address", 32'(bus_addr), 32'(expected_wr.addr));
				compare_value("write data", 32'(bus_wdata), 32'(expected_wr.data));
				compare_value("write io flag", 32'(bus_io), 32'(expected_wr.io));
				writes_seen = writes_seen + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			stop_on_failure($sformatf("Timeout: the run did not reach HLT within %0d cycles",
				cycle_limit));
		end
	end

	initial begin
		logic [15:0] fill_addr;
		$timeformat(-9, 0, " ns", 0);
		seed      = 32'h417def18;
		fill_addr = 16'h0000;
		repeat (65536) begin
			mem[fill_addr]     = fill_addr[7:0] ^ fill_addr[15:8] ^ 8'hA5;
			ref_mem[fill_addr] = fill_addr[7:0] ^ fill_addr[15:8] ^ 8'hA5;
			fill_addr          = fill_addr + 16'd1;
		end
		build_program();
		ref_steps   = run_reference();
		// Up to 4 bus cycles of at most 6 clocks each per instruction
		cycle_limit = 6 * 4 * (ref_steps + 20);
		$display("Program %0d bytes, %0d instructions, %0d writes expected", gen_pc,
			ref_steps, exp_q.size());
		wait (hlt_fetched);
		repeat (100) @(posedge clk);
		@(negedge clk);
		compare_value("strobes after HLT", 32'(strobes_after_halt), 32'd0);
		if (exp_q.size() != 0) begin
			stop_on_failure($sformatf("%0d expected writes never appeared on the bus",
				exp_q.size()));
		end else begin
			$display("Compared %0d writes", writes_seen);
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// File: tb/tb_clock_gen.sv
// Clock and synchronous reset source; reset drops on the rising edge that ends P_RST_CYCLES
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int P_PERIOD     = 20,
	parameter int P_RST_CYCLES = 10
) (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #(P_PERIOD / 2) o_clk = ~o_clk;
	end

	// Held high for the first P_RST_CYCLES rising edges
	initial begin
		o_rst <= 1'b1;
		repeat (P_RST_CYCLES) @(posedge o_clk);
		o_rst <= 1'b0;
	end

endmodule
